// ==== sources.f ====
rtl/sdhc_pkg.sv
rtl/sram_shift_reg.sv
rtl/dat_buffer.sv
rtl/sdhc_regs.sv
rtl/sdhc_xfer_ctrl.sv
rtl/sdhc_data_subsys.sv
bench/dat_buffer_chk.sv
bench/tb_sdhc_data_subsys.sv

// ==== Makefile ====
TOP := tb_sdhc_data_subsys

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

lint:
	verilator --lint-only -Wall --timing -f sources.f --top-module sdhc_data_subsys

clean:
	rm -rf obj_dir

// ==== bench/tb_sdhc_data_subsys.sv ====
`default_nettype none

module tb_sdhc_data_subsys;
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    logic                   read;
    logic                   multi;
    logic [11:0]            size;
    sdhc_pkg::block_count_t count;
    sdhc_pkg::block_count_t final_count;
  } xfer_case_t;

  localparam int NUM_CASES = 5;

  // Direction, multi, block size in bytes, block count, final count.
  xfer_case_t cases [NUM_CASES] = '{
    '{1'b1, 1'b0, 12'd64, 16'd1, 16'd1},
    '{1'b0, 1'b1, 12'd32, 16'd3, 16'd0},
    '{1'b1, 1'b0, 12'd6,  16'd1, 16'd1},
    '{1'b0, 1'b1, 12'd6,  16'd2, 16'd0},
    '{1'b1, 1'b1, 12'd32, 16'd2, 16'd0}
  };

  logic                clk = 1'b0;
  logic                reset = 1'b1;
  sdhc_pkg::reg_addr_e reg_addr = sdhc_pkg::REG_BLOCK_SIZE;
  sdhc_pkg::word_t     reg_wdata = '0;
  logic                reg_we = 1'b0;
  logic                reg_re = 1'b0;
  sdhc_pkg::word_t     reg_rdata;
  logic                card_rx_valid = 1'b0;
  sdhc_pkg::word_t     card_rx_data = '0;
  logic                card_rx_ready;
  logic                card_tx_valid;
  sdhc_pkg::word_t     card_tx_data;
  logic                card_tx_ready = 1'b0;

  sdhc_pkg::word_t rx_queue [$]; // Words the card still has to send.
  sdhc_pkg::word_t expect_q [$];
  logic [31:0]     data_lfsr = 32'h139f;
  logic [31:0]     ready_lfsr = 32'h139f;
  logic            rx_fire = 1'b0;
  int              rx_delivered = 0;
  int              host_popped = 0;
  int              word_errors = 0;
  int              count_errors = 0;
  int              bit_errors = 0;
  string           test_name = "reset";

  sdhc_data_subsys u_dut (
    .clk_i           (clk),
    .reset_i         (reset),
    .reg_addr_i      (reg_addr),
    .reg_wdata_i     (reg_wdata),
    .reg_we_i        (reg_we),
    .reg_re_i        (reg_re),
    .reg_rdata_o     (reg_rdata),
    .card_rx_valid_i (card_rx_valid),
    .card_rx_data_i  (card_rx_data),
    .card_rx_ready_o (card_rx_ready),
    .card_tx_valid_o (card_tx_valid),
    .card_tx_data_o  (card_tx_data),
    .card_tx_ready_i (card_tx_ready)
  );

  always #50 clk = ~clk;

  // Fibonacci LFSR with taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic int block_words(input xfer_case_t c);
    return (int'(c.size) + 3) / 4; // Bytes rounded up to words.
  endfunction

  function automatic int num_blocks(input xfer_case_t c);
    return c.multi ? int'(c.count) : 1;
  endfunction

  task automatic next_word(output sdhc_pkg::word_t w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      data_lfsr = lfsr_step(data_lfsr);
      w = {w[30:0], data_lfsr[0]};
    end
  endtask

  task automatic check_word(input string what, input sdhc_pkg::word_t exp,
                            input sdhc_pkg::word_t act);
    if (act !== exp) begin
      word_errors++;
      $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_count(input string what, input sdhc_pkg::block_count_t exp,
                             input sdhc_pkg::block_count_t act);
    if (act !== exp) begin
      count_errors++;
      $display("[ERROR] %s %s: expected %0d, actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      bit_errors++;
      $display("[ERROR] %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic write_reg(input sdhc_pkg::reg_addr_e addr, input sdhc_pkg::word_t data);
    @(posedge clk);
    reg_addr  <= addr;
    reg_wdata <= data;
    reg_we    <= 1'b1;
    @(posedge clk);
    reg_we <= 1'b0;
  endtask

  // With pop set, the word is removed at the edge after the sample.
  task automatic read_reg(input sdhc_pkg::reg_addr_e addr, input logic pop,
                          output sdhc_pkg::word_t data);
    @(posedge clk);
    reg_addr <= addr;
    reg_re   <= pop;
    @(negedge clk);
    data = reg_rdata;
    if (pop) begin
      @(posedge clk);
      reg_re <= 1'b0;
    end
  endtask

  task automatic read_block(input int words);
    sdhc_pkg::word_t ps;
    sdhc_pkg::word_t rd;
    do begin
      read_reg(sdhc_pkg::REG_PRESENT_STATE, 1'b0, ps);
      check_bit("read enable", (rx_delivered - host_popped) >= words,
                ps[sdhc_pkg::PS_READ_EN_BIT]);
    end while (!ps[sdhc_pkg::PS_READ_EN_BIT]);
    for (int i = 0; i < words; i++) begin
      read_reg(sdhc_pkg::REG_BUFFER_DATA, 1'b1, rd);
      host_popped++;
      check_word("buffer data", expect_q.pop_front(), rd);
    end
  endtask

  task automatic write_block(input int words);
    sdhc_pkg::word_t ps;
    sdhc_pkg::word_t w;
    do begin
      read_reg(sdhc_pkg::REG_PRESENT_STATE, 1'b0, ps);
    end while (!ps[sdhc_pkg::PS_WRITE_EN_BIT]);
    for (int i = 0; i < words; i++) begin
      next_word(w);
      write_reg(sdhc_pkg::REG_BUFFER_DATA, w);
      expect_q.push_back(w);
    end
  endtask

  // Handshakes are judged midway through the cycle that ends in the transfer.
  always @(negedge clk) rx_fire = card_rx_valid && card_rx_ready;

  always @(posedge clk) begin
    if (rx_fire) begin
      void'(rx_queue.pop_front());
      rx_delivered++;
    end
    if (rx_queue.size() != 0) begin
      card_rx_valid <= 1'b1;
      card_rx_data  <= rx_queue[0];
    end else begin
      card_rx_valid <= 1'b0;
    end
  end

  always @(posedge clk) begin
    ready_lfsr = lfsr_step(ready_lfsr);
    card_tx_ready <= ready_lfsr[0];
  end

  always @(negedge clk) begin
    if (card_tx_valid && card_tx_ready) begin
      if (expect_q.size() == 0) begin
        word_errors++;
        $display("%s: the card stream sent a word that the host never wrote", test_name);
      end else begin
        check_word("card tx data", expect_q.pop_front(), card_tx_data);
      end
    end
  end

  initial begin : main
    sdhc_pkg::word_t rd;
    sdhc_pkg::word_t w;
    xfer_case_t      tc;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    read_reg(sdhc_pkg::REG_PRESENT_STATE, 1'b0, rd);
    check_word("present state", '0, rd);
    read_reg(sdhc_pkg::REG_INT_STATUS, 1'b0, rd);
    check_word("interrupt status", '0, rd);
    check_bit("card rx ready", 1'b0, card_rx_ready);
    check_bit("card tx valid", 1'b0, card_tx_valid);

    for (int n = 0; n < NUM_CASES; n++) begin
      tc = cases[n];
      test_name = $sformatf("case%0d", n);
      write_reg(sdhc_pkg::REG_BLOCK_SIZE, 32'(tc.size));
      write_reg(sdhc_pkg::REG_BLOCK_COUNT, 32'(tc.count));
      write_reg(sdhc_pkg::REG_XFER_MODE, (32'(tc.read) << sdhc_pkg::MODE_READ_BIT) |
                                         (32'(tc.multi) << sdhc_pkg::MODE_MULTI_BIT));
      if (tc.read) begin
        for (int i = 0; i < num_blocks(tc) * block_words(tc); i++) begin
          next_word(w);
          rx_queue.push_back(w);
          expect_q.push_back(w);
        end
      end
      write_reg(sdhc_pkg::REG_COMMAND, '0);
      for (int b = 0; b < num_blocks(tc); b++) begin
        if (tc.read) begin
          read_block(block_words(tc));
        end else begin
          write_block(block_words(tc));
        end
      end
      do begin
        read_reg(sdhc_pkg::REG_INT_STATUS, 1'b0, rd);
      end while (!rd[sdhc_pkg::INT_XFER_DONE_BIT]);
      read_reg(sdhc_pkg::REG_BLOCK_COUNT, 1'b0, rd);
      check_count("final block count", tc.final_count, sdhc_pkg::block_count_t'(rd));
      check_bit("all data delivered", 1'b1, expect_q.size() == 0);
      read_reg(sdhc_pkg::REG_PRESENT_STATE, 1'b0, rd);
      check_word("present state idle", '0, rd);
      write_reg(sdhc_pkg::REG_INT_STATUS, 32'(1) << sdhc_pkg::INT_XFER_DONE_BIT);
      read_reg(sdhc_pkg::REG_INT_STATUS, 1'b0, rd);
      check_bit("done cleared", 1'b0, rd[sdhc_pkg::INT_XFER_DONE_BIT]);
    end

    $display("errors: data %0d, count %0d, flag %0d", word_errors, count_errors, bit_errors);
    if (word_errors + count_errors + bit_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    int limit;
    limit = 1000;
    foreach (cases[i]) limit += 40 * num_blocks(cases[i]) * block_words(cases[i]);
    repeat (limit) @(posedge clk);
    $display("Timeout: the transfers did not finish within %0d cycles", limit);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/dat_buffer_chk.sv ====
`default_nettype none

module dat_buffer_chk (
  input wire logic clk_i,
  input wire logic reset_i,
  input wire logic read_operation_i,
  input wire logic write_operation_i,
  input wire logic fifo_push_i,
  input wire logic fifo_pop_i,
  input wire logic fifo_full_i,
  input wire logic fifo_empty_i,
  input wire logic buf_port_we_i,
  input wire logic buf_port_re_i,
  input wire logic block_count_we_i
);
  timeunit 1ns;
  timeprecision 1ps;

  no_push_when_full: assert property (@(posedge clk_i) disable iff (reset_i)
    !(fifo_push_i && fifo_full_i))
    else $error("FIFO push while full");

  no_pop_when_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    !(fifo_pop_i && fifo_empty_i))
    else $error("FIFO pop while empty");

  one_direction: assert property (@(posedge clk_i) disable iff (reset_i)
    !(read_operation_i && write_operation_i))
    else $error("read and write operation both active");

  // The block count only moves on a host port access that moves a word.
  count_on_host_access: assert property (@(posedge clk_i) disable iff (reset_i)
    block_count_we_i |-> (read_operation_i ? (buf_port_re_i && !fifo_empty_i)
                                           : (buf_port_we_i && !fifo_full_i)))
    else $error("block count update without a host port word transfer");

endmodule

bind dat_buffer dat_buffer_chk u_chk (
  .clk_i             (clk_i),
  .reset_i           (reset_i),
  .read_operation_i  (read_operation_i),
  .write_operation_i (write_operation_i),
  .fifo_push_i       (fifo_push),
  .fifo_pop_i        (fifo_pop),
  .fifo_full_i       (fifo_full),
  .fifo_empty_i      (fifo_empty),
  .buf_port_we_i     (buf_port_we_i),
  .buf_port_re_i     (buf_port_re_i),
  .block_count_we_i  (block_count_we_o)
);

`default_nettype wire

// ==== rtl/sdhc_data_subsys.sv ====
`default_nettype none

module sdhc_data_subsys (
  input  wire logic                clk_i,
  input  wire logic                reset_i,
  input  wire sdhc_pkg::reg_addr_e reg_addr_i,
  input  wire sdhc_pkg::word_t     reg_wdata_i,
  input  wire logic                reg_we_i,
  input  wire logic                reg_re_i,
  output sdhc_pkg::word_t          reg_rdata_o,
  input  wire logic                card_rx_valid_i,
  input  wire sdhc_pkg::word_t     card_rx_data_i,
  output logic                     card_rx_ready_o,
  output logic                     card_tx_valid_o,
  output sdhc_pkg::word_t          card_tx_data_o,
  input  wire logic                card_tx_ready_i
);

  logic [sdhc_pkg::MAX_BLOCK_BITS-1:0] block_size;
  sdhc_pkg::block_count_t              block_count, block_count_next;
  sdhc_pkg::word_t                     buf_port_wdata, buf_port_rdata;
  logic multi_block, buf_port_we, buf_port_re, block_count_we;
  logic buffer_write_en, buffer_read_en, start, dir_read, active, xfer_done;
  logic read_operation, write_operation, last_block, empty;

  sdhc_regs u_regs (
    .clk_i              (clk_i),
    .reset_i            (reset_i),
    .reg_addr_i         (reg_addr_i),
    .reg_wdata_i        (reg_wdata_i),
    .reg_we_i           (reg_we_i),
    .reg_re_i           (reg_re_i),
    .reg_rdata_o        (reg_rdata_o),
    .block_size_o       (block_size),
    .block_count_o      (block_count),
    .multi_block_o      (multi_block),
    .buf_port_we_o      (buf_port_we),
    .buf_port_re_o      (buf_port_re),
    .buf_port_wdata_o   (buf_port_wdata),
    .buf_port_rdata_i   (buf_port_rdata),
    .block_count_we_i   (block_count_we),
    .block_count_next_i (block_count_next),
    .buffer_write_en_i  (buffer_write_en),
    .buffer_read_en_i   (buffer_read_en),
    .start_o            (start),
    .dir_read_o         (dir_read),
    .active_i           (active),
    .xfer_done_i        (xfer_done)
  );

  sdhc_xfer_ctrl u_ctrl (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .start_i           (start),
    .dir_read_i        (dir_read),
    .last_block_i      (last_block),
    .empty_i           (empty),
    .read_operation_o  (read_operation),
    .write_operation_o (write_operation),
    .active_o          (active),
    .xfer_done_o       (xfer_done)
  );

  dat_buffer u_buffer (
    .clk_i              (clk_i),
    .reset_i            (reset_i),
    .read_operation_i   (read_operation),
    .write_operation_i  (write_operation),
    .card_rx_valid_i    (card_rx_valid_i),
    .card_rx_data_i     (card_rx_data_i),
    .card_rx_ready_o    (card_rx_ready_o),
    .card_tx_ready_i    (card_tx_ready_i),
    .card_tx_valid_o    (card_tx_valid_o),
    .card_tx_data_o     (card_tx_data_o),
    .block_size_i       (block_size),
    .block_count_i      (block_count),
    .multi_block_i      (multi_block),
    .buf_port_we_i      (buf_port_we),
    .buf_port_re_i      (buf_port_re),
    .buf_port_wdata_i   (buf_port_wdata),
    .buf_port_rdata_o   (buf_port_rdata),
    .buffer_write_en_o  (buffer_write_en),
    .buffer_read_en_o   (buffer_read_en),
    .block_count_we_o   (block_count_we),
    .block_count_next_o (block_count_next),
    .last_block_o       (last_block),
    .empty_o            (empty)
  );

endmodule

`default_nettype wire

// ==== rtl/sdhc_xfer_ctrl.sv ====
`default_nettype none

module sdhc_xfer_ctrl (
  input  wire logic clk_i,
  input  wire logic reset_i,
  input  wire logic start_i,
  input  wire logic dir_read_i,
  input  wire logic last_block_i,
  input  wire logic empty_i,
  output logic      read_operation_o,
  output logic      write_operation_o,
  output logic      active_o,
  output logic      xfer_done_o
);

  sdhc_pkg::xfer_state_e state_q, state_d;
  logic                  dir_read_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      sdhc_pkg::XFER_IDLE:   if (start_i) state_d = sdhc_pkg::XFER_ACTIVE;
      sdhc_pkg::XFER_ACTIVE: if (last_block_i) state_d = sdhc_pkg::XFER_DRAIN;
      sdhc_pkg::XFER_DRAIN:  if (empty_i) state_d = sdhc_pkg::XFER_IDLE;
      default:               state_d = sdhc_pkg::XFER_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= sdhc_pkg::XFER_IDLE;
      dir_read_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == sdhc_pkg::XFER_IDLE && start_i) dir_read_q <= dir_read_i;
    end
  end

  // Operation levels stay up while draining the last block.
  assign active_o          = (state_q != sdhc_pkg::XFER_IDLE);
  assign read_operation_o  = active_o && dir_read_q;
  assign write_operation_o = active_o && !dir_read_q;
  assign xfer_done_o       = (state_q == sdhc_pkg::XFER_DRAIN) && empty_i;

endmodule

`default_nettype wire

// ==== rtl/sdhc_regs.sv ====
`default_nettype none

module sdhc_regs (
  input  wire logic                                clk_i,
  input  wire logic                                reset_i,
  input  wire sdhc_pkg::reg_addr_e                 reg_addr_i,
  input  wire sdhc_pkg::word_t                     reg_wdata_i,
  input  wire logic                                reg_we_i,
  input  wire logic                                reg_re_i,
  output sdhc_pkg::word_t                          reg_rdata_o,
  output logic [sdhc_pkg::MAX_BLOCK_BITS-1:0]      block_size_o,
  output sdhc_pkg::block_count_t                   block_count_o,
  output logic                                     multi_block_o,
  output logic                                     buf_port_we_o,
  output logic                                     buf_port_re_o,
  output sdhc_pkg::word_t                          buf_port_wdata_o,
  input  wire sdhc_pkg::word_t                     buf_port_rdata_i,
  input  wire logic                                block_count_we_i,
  input  wire sdhc_pkg::block_count_t              block_count_next_i,
  input  wire logic                                buffer_write_en_i,
  input  wire logic                                buffer_read_en_i,
  output logic                                     start_o,
  output logic                                     dir_read_o,
  input  wire logic                                active_i,
  input  wire logic                                xfer_done_i
);

  logic [sdhc_pkg::MAX_BLOCK_BITS-1:0] block_size_q;
  sdhc_pkg::block_count_t              block_count_q;
  logic                                mode_multi_q, mode_read_q;
  logic                                int_done_q;
  logic                                wr_size, wr_count, wr_mode, wr_int;

  assign wr_size  = reg_we_i && (reg_addr_i == sdhc_pkg::REG_BLOCK_SIZE);
  assign wr_count = reg_we_i && (reg_addr_i == sdhc_pkg::REG_BLOCK_COUNT);
  assign wr_mode  = reg_we_i && (reg_addr_i == sdhc_pkg::REG_XFER_MODE);
  assign wr_int   = reg_we_i && (reg_addr_i == sdhc_pkg::REG_INT_STATUS);

  assign start_o    = reg_we_i && (reg_addr_i == sdhc_pkg::REG_COMMAND);
  assign dir_read_o = mode_read_q;

  assign buf_port_we_o    = reg_we_i && (reg_addr_i == sdhc_pkg::REG_BUFFER_DATA);
  assign buf_port_re_o    = reg_re_i && (reg_addr_i == sdhc_pkg::REG_BUFFER_DATA);
  assign buf_port_wdata_o = reg_wdata_i;

  assign block_size_o  = block_size_q;
  assign block_count_o = block_count_q;
  assign multi_block_o = mode_multi_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      block_size_q  <= '0;
      block_count_q <= '0;
      mode_multi_q  <= 1'b0;
      mode_read_q   <= 1'b0;
      int_done_q    <= 1'b0;
    end else begin
      if (wr_size) block_size_q <= reg_wdata_i[sdhc_pkg::MAX_BLOCK_BITS-1:0];
      if (wr_count)              block_count_q <= sdhc_pkg::block_count_t'(reg_wdata_i);
      else if (block_count_we_i) block_count_q <= block_count_next_i;
      if (wr_mode) begin
        mode_multi_q <= reg_wdata_i[sdhc_pkg::MODE_MULTI_BIT];
        mode_read_q  <= reg_wdata_i[sdhc_pkg::MODE_READ_BIT];
      end
      // A new completion wins over a clear in the same cycle.
      if (xfer_done_i) int_done_q <= 1'b1;
      else if (wr_int && reg_wdata_i[sdhc_pkg::INT_XFER_DONE_BIT]) int_done_q <= 1'b0;
    end
  end

  always_comb begin
    reg_rdata_o = '0;
    case (reg_addr_i)
      sdhc_pkg::REG_BLOCK_SIZE:  reg_rdata_o = sdhc_pkg::word_t'(block_size_q);
      sdhc_pkg::REG_BLOCK_COUNT: reg_rdata_o = sdhc_pkg::word_t'(block_count_q);
      sdhc_pkg::REG_XFER_MODE: begin
        reg_rdata_o[sdhc_pkg::MODE_MULTI_BIT] = mode_multi_q;
        reg_rdata_o[sdhc_pkg::MODE_READ_BIT]  = mode_read_q;
      end
      sdhc_pkg::REG_BUFFER_DATA: reg_rdata_o = buf_port_rdata_i; // Word being popped.
      sdhc_pkg::REG_PRESENT_STATE: begin
        reg_rdata_o[sdhc_pkg::PS_WRITE_EN_BIT] = buffer_write_en_i;
        reg_rdata_o[sdhc_pkg::PS_READ_EN_BIT]  = buffer_read_en_i;
        reg_rdata_o[sdhc_pkg::PS_ACTIVE_BIT]   = active_i;
      end
      sdhc_pkg::REG_INT_STATUS: reg_rdata_o[sdhc_pkg::INT_XFER_DONE_BIT] = int_done_q;
      default: reg_rdata_o = '0; // Command reads back as zero.
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/dat_buffer.sv ====
`default_nettype none

module dat_buffer (
  input  wire logic                              clk_i,
  input  wire logic                              reset_i,
  input  wire logic                              read_operation_i,
  input  wire logic                              write_operation_i,
  input  wire logic                              card_rx_valid_i,
  input  wire sdhc_pkg::word_t                   card_rx_data_i,
  output logic                                   card_rx_ready_o,
  input  wire logic                              card_tx_ready_i,
  output logic                                   card_tx_valid_o,
  output sdhc_pkg::word_t                        card_tx_data_o,
  input  wire logic [sdhc_pkg::MAX_BLOCK_BITS-1:0] block_size_i,
  input  wire sdhc_pkg::block_count_t            block_count_i,
  input  wire logic                              multi_block_i,
  input  wire logic                              buf_port_we_i,
  input  wire logic                              buf_port_re_i,
  input  wire sdhc_pkg::word_t                   buf_port_wdata_i,
  output sdhc_pkg::word_t                        buf_port_rdata_o,
  output logic                                   buffer_write_en_o,
  output logic                                   buffer_read_en_o,
  output logic                                   block_count_we_o,
  output sdhc_pkg::block_count_t                 block_count_next_o,
  output logic                                   last_block_o,
  output logic                                   empty_o
);

  logic [sdhc_pkg::MAX_BLOCK_BITS:0]   size_round;
  logic [sdhc_pkg::MAX_BLOCK_BITS-2:0] block_words, len_words, free_words, card_remaining;
  logic [sdhc_pkg::MAX_BLOCK_BITS-2:0] word_cnt_q, card_cnt_q;
  logic [sdhc_pkg::LEN_BITS-1:0]       fifo_len;
  logic                                fifo_en, fifo_push, fifo_pop, fifo_full, fifo_empty;
  sdhc_pkg::word_t                     fifo_push_data, fifo_front;
  logic                                has_block, has_space;
  logic                                host_access, host_block_end, card_xfer, card_block_end;

  // Block size in bytes, rounded up to whole words.
  assign size_round  = {1'b0, block_size_i} + (sdhc_pkg::MAX_BLOCK_BITS + 1)'(3);
  assign block_words = size_round[sdhc_pkg::MAX_BLOCK_BITS:2];

  assign len_words  = (sdhc_pkg::MAX_BLOCK_BITS - 1)'(fifo_len);
  assign free_words = (sdhc_pkg::MAX_BLOCK_BITS - 1)'(sdhc_pkg::BUF_WORDS) - len_words;
  assign has_block  = len_words >= block_words;
  assign has_space  = free_words >= block_words;

  // The card side may finish a block it has started.
  assign card_remaining = block_words - card_cnt_q;

  assign fifo_en = read_operation_i || write_operation_i;
  assign empty_o = fifo_empty;

  assign card_rx_ready_o = read_operation_i && !fifo_full && (free_words >= card_remaining);
  assign card_tx_valid_o = write_operation_i && !fifo_empty && (len_words >= card_remaining);
  assign card_tx_data_o  = fifo_front;
  assign buf_port_rdata_o = fifo_front;

  assign fifo_push      = read_operation_i ? (card_rx_valid_i && card_rx_ready_o) : buf_port_we_i;
  assign fifo_push_data = read_operation_i ? card_rx_data_i : buf_port_wdata_i;
  assign fifo_pop       = read_operation_i ? buf_port_re_i : (card_tx_ready_i && card_tx_valid_o);

  assign host_access    = (read_operation_i && buf_port_re_i) ||
                          (write_operation_i && buf_port_we_i);
  assign host_block_end = host_access && (word_cnt_q == block_words - 1'b1);
  assign card_xfer      = (card_rx_valid_i && card_rx_ready_o) ||
                          (card_tx_ready_i && card_tx_valid_o);
  assign card_block_end = card_xfer && (card_cnt_q == block_words - 1'b1);

  assign block_count_next_o = block_count_i - 1'b1;
  assign block_count_we_o   = host_block_end && multi_block_i;
  assign last_block_o       = host_block_end && (!multi_block_i || block_count_i == 16'd1);

  always_comb begin
    buffer_read_en_o  = read_operation_i && has_block;
    buffer_write_en_o = write_operation_i && has_space;
    if (block_count_we_o && block_count_i != 16'd1) begin
      buffer_read_en_o  = 1'b0; // Block boundary with more to come.
      buffer_write_en_o = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || !fifo_en) begin
      word_cnt_q <= '0;
      card_cnt_q <= '0;
    end else begin
      if (host_access) word_cnt_q <= host_block_end ? '0 : word_cnt_q + 1'b1;
      if (card_xfer)   card_cnt_q <= card_block_end ? '0 : card_cnt_q + 1'b1;
    end
  end

  sram_shift_reg u_fifo (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .en_i         (fifo_en),
    .push_back_i  (fifo_push),
    .back_data_i  (fifo_push_data),
    .pop_front_i  (fifo_pop),
    .front_data_o (fifo_front),
    .full_o       (fifo_full),
    .empty_o      (fifo_empty),
    .length_o     (fifo_len)
  );

endmodule

`default_nettype wire

// ==== rtl/sram_shift_reg.sv ====
`default_nettype none

module sram_shift_reg (
  input  wire logic                            clk_i,
  input  wire logic                            reset_i,
  input  wire logic                            en_i,
  input  wire logic                            push_back_i,
  input  wire sdhc_pkg::word_t                 back_data_i,
  input  wire logic                            pop_front_i,
  output sdhc_pkg::word_t                      front_data_o,
  output logic                                 full_o,
  output logic                                 empty_o,
  output logic [sdhc_pkg::LEN_BITS-1:0]        length_o
);

  sdhc_pkg::word_t mem [sdhc_pkg::BUF_WORDS];

  // Pointers wrap naturally since the depth is a power of two.
  logic [$clog2(sdhc_pkg::BUF_WORDS)-1:0] wr_ptr_q, rd_ptr_q;
  logic [sdhc_pkg::LEN_BITS-1:0]          length_q;
  logic                                   do_push, do_pop;

  assign full_o   = (length_q == sdhc_pkg::LEN_BITS'(sdhc_pkg::BUF_WORDS));
  assign empty_o  = (length_q == '0);
  assign length_o = length_q;

  assign do_push = en_i && push_back_i && !full_o;
  assign do_pop  = en_i && pop_front_i && !empty_o;

  assign front_data_o = mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      length_q <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      if (do_push && !do_pop)      length_q <= length_q + 1'b1;
      else if (do_pop && !do_push) length_q <= length_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem[wr_ptr_q] <= back_data_i;
  end

endmodule

`default_nettype wire

// ==== rtl/sdhc_pkg.sv ====
`default_nettype none

package sdhc_pkg;

  localparam int BUF_WORDS      = 16; // Buffer depth, a power of two.
  localparam int MAX_BLOCK_BITS = 12;
  localparam int LEN_BITS       = $clog2(BUF_WORDS + 1);

  typedef logic [31:0] word_t;
  typedef logic [15:0] block_count_t;

  typedef enum logic [2:0] {
    REG_BLOCK_SIZE    = 3'd0,
    REG_BLOCK_COUNT   = 3'd1,
    REG_XFER_MODE     = 3'd2,
    REG_COMMAND       = 3'd3,
    REG_BUFFER_DATA   = 3'd4,
    REG_PRESENT_STATE = 3'd5,
    REG_INT_STATUS    = 3'd6
  } reg_addr_e;

  typedef enum logic [1:0] {
    XFER_IDLE   = 2'd0,
    XFER_ACTIVE = 2'd1,
    XFER_DRAIN  = 2'd2
  } xfer_state_e;

  // Transfer mode register.
  localparam int MODE_READ_BIT  = 4;
  localparam int MODE_MULTI_BIT = 5;

  // Present state register.
  localparam int PS_ACTIVE_BIT   = 1;
  localparam int PS_WRITE_EN_BIT = 10;
  localparam int PS_READ_EN_BIT  = 11;

  localparam int INT_XFER_DONE_BIT = 1; // Write one to clear.

endpackage

`default_nettype wire
